/* design/exec_pkg.sv */
`default_nettype none

package exec_pkg;

    localparam int xlen          = 32;
    localparam int rob_idx_bits  = 6;
    localparam int phys_reg_bits = 6;
    localparam int arch_reg_bits = 5;
    // fixed latency from request to cdb
    localparam int mult_stages   = 4;

    typedef enum logic [1:0] {
        fu_alu_sel  = 2'd0,
        fu_mult_sel = 2'd1,
        fu_br_sel   = 2'd2
    } fu_sel_t;

    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_sll  = 4'd5,
        alu_srl  = 4'd6,
        alu_sra  = 4'd7,
        alu_slt  = 4'd8,
        alu_sltu = 4'd9
    } alu_op_t;

    // same order as the funct3 field of the M extension
    typedef enum logic [1:0] {
        mult_mul    = 2'd0,
        mult_mulh   = 2'd1,
        mult_mulhsu = 2'd2,
        mult_mulhu  = 2'd3
    } mult_op_t;

    // conditional branches use their funct3, jal takes a spare code
    typedef enum logic [2:0] {
        br_beq  = 3'b000,
        br_bne  = 3'b001,
        br_jal  = 3'b010,
        br_blt  = 3'b100,
        br_bge  = 3'b101,
        br_bltu = 3'b110,
        br_bgeu = 3'b111
    } br_op_t;

    typedef struct packed {
        logic [rob_idx_bits-1:0]  rob_idx;
        logic [phys_reg_bits-1:0] pd;
        logic [arch_reg_bits-1:0] rd;
    } tag_t;

    // op is wide enough for any unit's opcode
    typedef struct packed {
        logic            valid;
        logic [3:0]      op;
        logic [xlen-1:0] rs1_v;
        logic [xlen-1:0] rs2_v;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        tag_t            tag;
    } fu_req_t;

    typedef struct packed {
        fu_sel_t         fu_sel;
        logic [3:0]      op;
        logic [xlen-1:0] rs1_v;
        logic [xlen-1:0] rs2_v;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        tag_t            tag;
    } issue_pkt_t;

    typedef struct packed {
        logic            valid;
        tag_t            tag;
        logic [xlen-1:0] rd_v;
        logic            pc_select;
        logic [xlen-1:0] pc_branch;
    } cdb_t;

endpackage

`default_nettype wire

/* design/issue_wb_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module issue_wb_slave (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                wb_cyc,
    input  logic                wb_stb,
    input  logic                wb_we,
    input  exec_pkg::issue_pkt_t wb_dat,
    output logic                wb_ack,
    input  logic                alu_ready,
    input  logic                mult_ready,
    input  logic                br_ready,
    output exec_pkg::fu_req_t   alu_req,
    output exec_pkg::fu_req_t   mult_req,
    output exec_pkg::fu_req_t   br_req
);
    import exec_pkg::*;

    logic    stb_seen;
    logic    sel_ready;
    fu_req_t req;

    always_comb begin
        case (wb_dat.fu_sel)
            fu_alu_sel:  sel_ready = alu_ready;
            fu_mult_sel: sel_ready = mult_ready;
            fu_br_sel:   sel_ready = br_ready;
            // unknown unit, ack so the bus moves on, nothing dispatched
            default:     sel_ready = 1'b1;
        endcase
    end

    // write strobe seen in the previous cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            stb_seen <= 1'b0;
        end else if (flush || wb_ack) begin
            stb_seen <= 1'b0;
        end else begin
            stb_seen <= wb_cyc && wb_stb && wb_we;
        end
    end

    assign wb_ack = stb_seen && wb_cyc && wb_stb && wb_we && sel_ready && !flush;

    always_comb begin
        req.valid = 1'b0;
        req.op    = wb_dat.op;
        req.rs1_v = wb_dat.rs1_v;
        req.rs2_v = wb_dat.rs2_v;
        req.pc    = wb_dat.pc;
        req.imm   = wb_dat.imm;
        req.tag   = wb_dat.tag;

        // payload fans out to all units, valid only to the target
        alu_req        = req;
        alu_req.valid  = wb_ack && (wb_dat.fu_sel == fu_alu_sel);
        mult_req       = req;
        mult_req.valid = wb_ack && (wb_dat.fu_sel == fu_mult_sel);
        br_req         = req;
        br_req.valid   = wb_ack && (wb_dat.fu_sel == fu_br_sel);
    end

    stb_needs_cyc: assert property (@(posedge clk) disable iff (rst)
        $rose(wb_stb) |-> wb_cyc);

    one_dispatch: assert property (@(posedge clk) disable iff (rst)
        $onehot0({alu_req.valid, mult_req.valid, br_req.valid}));

endmodule

`default_nettype wire

/* design/fu_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_alu (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  exec_pkg::fu_req_t req,
    input  logic              hold,
    output logic              ready,
    output exec_pkg::cdb_t    result
);
    import exec_pkg::*;

    alu_op_t                   op;
    logic [$clog2(xlen)-1:0]   shamt;
    logic [xlen-1:0]           alu_out;
    logic                      res_valid;
    cdb_t                      res_q;

    assign op    = alu_op_t'(req.op);
    // only the low bits count, so shifts of 32 and up wrap
    assign shamt = req.rs2_v[$clog2(xlen)-1:0];

    always_comb begin
        case (op)
            alu_add:  alu_out = req.rs1_v + req.rs2_v;
            alu_sub:  alu_out = req.rs1_v - req.rs2_v;
            alu_and:  alu_out = req.rs1_v & req.rs2_v;
            alu_or:   alu_out = req.rs1_v | req.rs2_v;
            alu_xor:  alu_out = req.rs1_v ^ req.rs2_v;
            alu_sll:  alu_out = req.rs1_v << shamt;
            alu_srl:  alu_out = req.rs1_v >> shamt;
            alu_sra:  alu_out = $signed(req.rs1_v) >>> shamt;
            alu_slt:  alu_out = {{(xlen-1){1'b0}}, $signed(req.rs1_v) < $signed(req.rs2_v)};
            alu_sltu: alu_out = {{(xlen-1){1'b0}}, req.rs1_v < req.rs2_v};
            default:  alu_out = '0;
        endcase
    end

    // holding register, emptied once the arbiter takes the result
    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (flush) begin
            res_valid <= 1'b0;
        end else if (req.valid) begin
            res_valid <= 1'b1;
        end else if (!hold) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            res_q.valid     <= 1'b1;
            res_q.tag       <= req.tag;
            res_q.rd_v      <= alu_out;
            res_q.pc_select <= 1'b0;
            res_q.pc_branch <= '0;
        end
    end

    always_comb begin
        result       = res_q;
        result.valid = res_valid;
    end

    // free, or the held result leaves this cycle
    assign ready = !res_valid || !hold;

    no_issue_into_held: assert property (@(posedge clk) disable iff (rst)
        (res_valid && hold) |-> !req.valid);

endmodule

`default_nettype wire

/* design/fu_mult.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_mult (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  exec_pkg::fu_req_t req,
    output exec_pkg::cdb_t    result
);
    import exec_pkg::*;

    mult_op_t                         op;
    logic                             sign_a;
    logic                             sign_b;
    logic [mult_stages:1]             stage_v;
    tag_t                             stage_tag [1:mult_stages];
    mult_op_t                         stage_op [1:mult_stages-1];
    logic signed [xlen:0]             s1_a;
    logic signed [xlen:0]             s1_b;
    logic signed [xlen+xlen/2+1:0]    s2_pp_lo;
    logic signed [xlen+xlen/2+1:0]    s2_pp_hi;
    logic [2*xlen-1:0]                s3_prod;
    logic [xlen-1:0]                  s4_rd_v;

    assign op     = mult_op_t'(req.op[1:0]);
    assign sign_a = (op == mult_mulh) || (op == mult_mulhsu);
    assign sign_b = (op == mult_mulh);

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_v <= '0;
        end else if (flush) begin
            stage_v <= '0;
        end else begin
            stage_v <= {stage_v[mult_stages-1:1], req.valid};
        end
    end

    // tag and opcode ride along with the data
    always_ff @(posedge clk) begin
        stage_tag[1] <= req.tag;
        stage_op[1]  <= op;
        for (int i = 2; i <= mult_stages; i++) begin
            stage_tag[i] <= stage_tag[i-1];
        end
        for (int i = 2; i < mult_stages; i++) begin
            stage_op[i] <= stage_op[i-1];
        end
    end

    always_ff @(posedge clk) begin
        // stage 1, 33 bit operands cover signed and unsigned
        s1_a     <= {sign_a & req.rs1_v[xlen-1], req.rs1_v};
        s1_b     <= {sign_b & req.rs2_v[xlen-1], req.rs2_v};
        // stage 2, b split into an unsigned low half and a signed high half
        s2_pp_lo <= s1_a * $signed({1'b0, s1_b[xlen/2-1:0]});
        s2_pp_hi <= s1_a * $signed(s1_b[xlen:xlen/2]);
        // stage 3
        s3_prod  <= (2*xlen)'(s2_pp_lo) + ((2*xlen)'(s2_pp_hi) << (xlen/2));
        // stage 4
        s4_rd_v  <= (stage_op[mult_stages-1] == mult_mul) ? s3_prod[xlen-1:0]
                                                          : s3_prod[2*xlen-1:xlen];
    end

    always_comb begin
        result.valid     = stage_v[mult_stages];
        result.tag       = stage_tag[mult_stages];
        result.rd_v      = s4_rd_v;
        result.pc_select = 1'b0;
        result.pc_branch = '0;
    end

    flush_empties_pipe: assert property (@(posedge clk) disable iff (rst)
        flush |=> (stage_v == '0));

endmodule

`default_nettype wire

/* design/fu_branch.sv */
`timescale 1ns/10ps
`default_nettype none

module fu_branch (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  exec_pkg::fu_req_t req,
    input  logic              hold,
    output logic              ready,
    output exec_pkg::cdb_t    result
);
    import exec_pkg::*;

    br_op_t op;
    logic   taken;
    logic   res_valid;
    cdb_t   res_q;

    assign op = br_op_t'(req.op[2:0]);

    always_comb begin
        case (op)
            br_beq:  taken = (req.rs1_v == req.rs2_v);
            br_bne:  taken = (req.rs1_v != req.rs2_v);
            br_blt:  taken = ($signed(req.rs1_v) < $signed(req.rs2_v));
            br_bge:  taken = ($signed(req.rs1_v) >= $signed(req.rs2_v));
            br_bltu: taken = (req.rs1_v < req.rs2_v);
            br_bgeu: taken = (req.rs1_v >= req.rs2_v);
            br_jal:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else if (flush) begin
            res_valid <= 1'b0;
        end else if (req.valid) begin
            res_valid <= 1'b1;
        end else if (!hold) begin
            res_valid <= 1'b0;
        end
    end

    // link value and target are computed for every op
    always_ff @(posedge clk) begin
        if (req.valid) begin
            res_q.valid     <= 1'b1;
            res_q.tag       <= req.tag;
            res_q.rd_v      <= req.pc + xlen'(4);
            res_q.pc_select <= taken;
            res_q.pc_branch <= req.pc + req.imm;
        end
    end

    always_comb begin
        result       = res_q;
        result.valid = res_valid;
    end

    assign ready = !res_valid || !hold;

endmodule

`default_nettype wire

/* design/cdb_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module cdb_arbiter (
    input  logic           flush,
    input  exec_pkg::cdb_t alu_res,
    input  exec_pkg::cdb_t mult_res,
    input  exec_pkg::cdb_t br_res,
    output logic           alu_hold,
    output logic           br_hold,
    output exec_pkg::cdb_t cdb
);
    // grant[0] multiplier, grant[1] alu, grant[2] branch
    logic [2:0] grant;

    // multiplier cannot stall, so it always goes first
    always_comb begin
        grant = 3'b000;
        if (mult_res.valid) begin
            grant[0] = 1'b1;
        end else if (alu_res.valid) begin
            grant[1] = 1'b1;
        end else if (br_res.valid) begin
            grant[2] = 1'b1;
        end
    end

    assign alu_hold = alu_res.valid && !grant[1];
    assign br_hold  = br_res.valid && !grant[2];

    always_comb begin
        cdb = '0;
        if (!flush) begin
            if (grant[0]) begin
                cdb = mult_res;
            end else if (grant[1]) begin
                cdb = alu_res;
            end else if (grant[2]) begin
                cdb = br_res;
            end
        end
    end

    grant_onehot: assert final ($onehot0(grant));

endmodule

`default_nettype wire

/* design/exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  exec_pkg::fu_req_t alu_req,
    input  exec_pkg::fu_req_t mult_req,
    input  exec_pkg::fu_req_t br_req,
    input  logic              alu_hold,
    input  logic              br_hold,
    output logic              alu_ready,
    output logic              br_ready,
    output exec_pkg::cdb_t    alu_res,
    output exec_pkg::cdb_t    mult_res,
    output exec_pkg::cdb_t    br_res
);

    // flush reaches every unit in the same edge

    fu_alu u_alu (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .req    (alu_req),
        .hold   (alu_hold),
        .ready  (alu_ready),
        .result (alu_res)
    );

    // no hold input, the arbiter always grants it
    fu_mult u_mult (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .req    (mult_req),
        .result (mult_res)
    );

    fu_branch u_branch (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .req    (br_req),
        .hold   (br_hold),
        .ready  (br_ready),
        .result (br_res)
    );

endmodule

`default_nettype wire

/* design/exec_top.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  logic                 wb_cyc,
    input  logic                 wb_stb,
    input  logic                 wb_we,
    input  exec_pkg::issue_pkt_t wb_dat,
    output logic                 wb_ack,
    output exec_pkg::cdb_t       cdb
);
    import exec_pkg::*;

    fu_req_t alu_req;
    fu_req_t mult_req;
    fu_req_t br_req;
    logic    alu_ready;
    logic    mult_ready;
    logic    br_ready;
    logic    alu_hold;
    logic    br_hold;
    cdb_t    alu_res;
    cdb_t    mult_res;
    cdb_t    br_res;

    // fully pipelined, never refuses an issue
    assign mult_ready = 1'b1;

    issue_wb_slave u_issue (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_dat     (wb_dat),
        .wb_ack     (wb_ack),
        .alu_ready  (alu_ready),
        .mult_ready (mult_ready),
        .br_ready   (br_ready),
        .alu_req    (alu_req),
        .mult_req   (mult_req),
        .br_req     (br_req)
    );

    exec_unit u_exec (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .alu_req   (alu_req),
        .mult_req  (mult_req),
        .br_req    (br_req),
        .alu_hold  (alu_hold),
        .br_hold   (br_hold),
        .alu_ready (alu_ready),
        .br_ready  (br_ready),
        .alu_res   (alu_res),
        .mult_res  (mult_res),
        .br_res    (br_res)
    );

    cdb_arbiter u_arb (
        .flush    (flush),
        .alu_res  (alu_res),
        .mult_res (mult_res),
        .br_res   (br_res),
        .alu_hold (alu_hold),
        .br_hold  (br_hold),
        .cdb      (cdb)
    );

endmodule

`default_nettype wire

/* dv/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset released a little after the third rising edge
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

`default_nettype wire

/* dv/exec_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_tb;
    import exec_pkg::*;

    localparam int num_pkts      = 400;
    localparam int num_flushes   = 4;
    localparam int timeout_limit = num_pkts * 20 + 100;
    localparam int drain_limit   = 50;

    logic       clk;
    logic       rst;
    logic       flush;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    issue_pkt_t wb_dat;
    logic       wb_ack;
    cdb_t       cdb;

    // scoreboard indexed by rob_idx
    logic       exp_valid [64];
    cdb_t       exp_cdb [64];
    logic       exp_mult [64];
    int         ack_cycle [64];
    int         pending;
    int         checked;
    int         flushed;
    int         cycles;
    int         flush_at [num_flushes];

    tb_clk_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    exec_top u_dut (
        .clk    (clk),
        .rst    (rst),
        .flush  (flush),
        .wb_cyc (wb_cyc),
        .wb_stb (wb_stb),
        .wb_we  (wb_we),
        .wb_dat (wb_dat),
        .wb_ack (wb_ack),
        .cdb    (cdb)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("mismatch at %0t: %s got %h expected %h",
                               $time, what, got, exp));
        end
    endtask

    function automatic logic [31:0] alu_model(input logic [3:0] op,
                                              input logic [31:0] a, input logic [31:0] b);
        case (alu_op_t'(op))
            alu_add:  return a + b;
            alu_sub:  return a - b;
            alu_and:  return a & b;
            alu_or:   return a | b;
            alu_xor:  return a ^ b;
            // RV32I shifts use only rs2[4:0]
            alu_sll:  return a << b[4:0];
            alu_srl:  return a >> b[4:0];
            alu_sra:  return $signed(a) >>> b[4:0];
            alu_slt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu: return (a < b) ? 32'd1 : 32'd0;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] mult_model(input logic [3:0] op,
                                               input logic [31:0] a, input logic [31:0] b);
        logic        a_signed;
        logic        b_signed;
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] prod;
        a_signed = (op[1:0] == mult_mulh) || (op[1:0] == mult_mulhsu);
        b_signed = (op[1:0] == mult_mulh);
        ea = {{32{a_signed & a[31]}}, a};
        eb = {{32{b_signed & b[31]}}, b};
        // product modulo 2^64 is exact for the top word too
        prod = ea * eb;
        return (op[1:0] == mult_mul) ? prod[31:0] : prod[63:32];
    endfunction

    function automatic logic branch_taken(input logic [3:0] op,
                                          input logic [31:0] a, input logic [31:0] b);
        case (br_op_t'(op[2:0]))
            br_beq:  return a == b;
            br_bne:  return a != b;
            br_blt:  return $signed(a) < $signed(b);
            br_bge:  return $signed(a) >= $signed(b);
            br_bltu: return a < b;
            br_bgeu: return a >= b;
            br_jal:  return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic cdb_t expected_result(input issue_pkt_t p);
        cdb_t r;
        r       = '0;
        r.valid = 1'b1;
        r.tag   = p.tag;
        case (p.fu_sel)
            fu_alu_sel:  r.rd_v = alu_model(p.op, p.rs1_v, p.rs2_v);
            fu_mult_sel: r.rd_v = mult_model(p.op, p.rs1_v, p.rs2_v);
            default: begin
                r.rd_v      = p.pc + 32'd4;
                r.pc_select = branch_taken(p.op, p.rs1_v, p.rs2_v);
                r.pc_branch = p.pc + p.imm;
            end
        endcase
        return r;
    endfunction

    // small values reach shift amounts of 31 and above
    function automatic logic [31:0] pick_operand();
        case ($urandom_range(0, 5))
            0:       return $urandom_range(0, 40);
            1:       return 32'hffff_ffff;
            2:       return 32'h8000_0000;
            default: return $urandom();
        endcase
    endfunction

    function automatic issue_pkt_t make_packet(input int idx);
        issue_pkt_t  p;
        logic [31:0] r;
        p.fu_sel = fu_sel_t'($urandom_range(0, 2));
        case (p.fu_sel)
            fu_alu_sel:  p.op = 4'($urandom_range(0, 9));
            fu_mult_sel: p.op = 4'($urandom_range(0, 3));
            default: begin
                case ($urandom_range(0, 6))
                    0:       p.op = {1'b0, br_beq};
                    1:       p.op = {1'b0, br_bne};
                    2:       p.op = {1'b0, br_blt};
                    3:       p.op = {1'b0, br_bge};
                    4:       p.op = {1'b0, br_bltu};
                    5:       p.op = {1'b0, br_bgeu};
                    default: p.op = {1'b0, br_jal};
                endcase
            end
        endcase
        p.rs1_v = pick_operand();
        p.rs2_v = ($urandom_range(0, 3) == 0) ? p.rs1_v : pick_operand();
        p.pc    = $urandom() & 32'hffff_fffc;
        r       = $urandom();
        p.imm   = {{19{r[12]}}, r[12:1], 1'b0};
        p.tag.rob_idx = 6'(idx);
        p.tag.pd      = 6'($urandom());
        p.tag.rd      = 5'($urandom());
        return p;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // entered 1 ns after a rising edge and holds the write until ack
    task automatic drive_packet(input issue_pkt_t pkt);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b1;
        wb_dat = pkt;
        @(negedge clk);
        while (!wb_ack) @(negedge clk);
        @(posedge clk);
        #1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_limit) begin
            fail_run($sformatf("at %0t: run did not finish within %0d cycles",
                               $time, timeout_limit));
        end
    end

    // scoreboard update and result check in the middle of each cycle
    always @(negedge clk) begin
        if (!rst) begin
            if (flush) begin
                if (cdb.valid) begin
                    fail_run($sformatf("at %0t: cdb valid during a flush", $time));
                end
                foreach (exp_valid[i]) exp_valid[i] = 1'b0;
                flushed = flushed + pending;
                pending = 0;
            end else if (cdb.valid) begin
                if (!exp_valid[cdb.tag.rob_idx]) begin
                    fail_run($sformatf("at %0t: result for rob index %0d that is not pending",
                                       $time, cdb.tag.rob_idx));
                end
                check_value("tag", cdb.tag, exp_cdb[cdb.tag.rob_idx].tag);
                check_value("rd_v", cdb.rd_v, exp_cdb[cdb.tag.rob_idx].rd_v);
                check_value("pc_select", cdb.pc_select, exp_cdb[cdb.tag.rob_idx].pc_select);
                check_value("pc_branch", cdb.pc_branch, exp_cdb[cdb.tag.rob_idx].pc_branch);
                if (exp_mult[cdb.tag.rob_idx]) begin
                    check_value("multiply latency", cycles - ack_cycle[cdb.tag.rob_idx],
                                mult_stages);
                end
                exp_valid[cdb.tag.rob_idx] = 1'b0;
                pending = pending - 1;
                checked = checked + 1;
            end
            if (wb_ack) begin
                if (exp_valid[wb_dat.tag.rob_idx]) begin
                    fail_run($sformatf("at %0t: rob index %0d issued while still pending",
                                       $time, wb_dat.tag.rob_idx));
                end
                exp_valid[wb_dat.tag.rob_idx] = 1'b1;
                exp_cdb[wb_dat.tag.rob_idx]   = expected_result(wb_dat);
                exp_mult[wb_dat.tag.rob_idx]  = (wb_dat.fu_sel == fu_mult_sel);
                ack_cycle[wb_dat.tag.rob_idx] = cycles;
                pending = pending + 1;
            end
        end
    end

    initial begin
        int t;
        int drained;
        flush   = 1'b0;
        wb_cyc  = 1'b0;
        wb_stb  = 1'b0;
        wb_we   = 1'b0;
        wb_dat  = '0;
        pending = 0;
        checked = 0;
        flushed = 0;
        cycles  = 0;
        foreach (exp_valid[i]) exp_valid[i] = 1'b0;
        void'($urandom(32'hee4f_e73b));

        t = 40;
        for (int i = 0; i < num_flushes; i++) begin
            t = t + $urandom_range(60, 200);
            flush_at[i] = t;
        end

        @(negedge rst);
        wait_cycles(2);
        fork
            begin
                for (int i = 0; i < num_flushes; i++) begin
                    while (cycles < flush_at[i]) wait_cycles(1);
                    flush = 1'b1;
                    wait_cycles(1);
                    flush = 1'b0;
                end
            end
            begin
                // idle gaps shift results onto the same cycle as multiplies
                for (int n = 0; n < num_pkts; n++) begin
                    drive_packet(make_packet(n % 64));
                    if ($urandom_range(0, 2) == 0) begin
                        wait_cycles($urandom_range(1, 2));
                    end
                end
            end
        join

        // lost results leave entries behind after the drain
        drained = 0;
        while (pending != 0 && drained < drain_limit) begin
            wait_cycles(1);
            drained = drained + 1;
        end
        // late duplicates would still show up here
        wait_cycles(10);
        $display("%0d results checked, %0d removed by flush", checked, flushed);
        if (pending != 0) begin
            fail_run($sformatf("at %0t: %0d results still pending", $time, pending));
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog.f */
design/exec_pkg.sv
design/issue_wb_slave.sv
design/fu_alu.sv
design/fu_mult.sv
design/fu_branch.sv
design/cdb_arbiter.sv
design/exec_unit.sv
design/exec_top.sv
dv/tb_clk_gen.sv
dv/exec_tb.sv

/* Bender.yml */
package:
  name: exec_stage

sources:
  - files:
      - design/exec_pkg.sv
      - design/issue_wb_slave.sv
      - design/fu_alu.sv
      - design/fu_mult.sv
      - design/fu_branch.sv
      - design/cdb_arbiter.sv
      - design/exec_unit.sv
      - design/exec_top.sv

  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/exec_tb.sv
